// File: list.f
source/smc_pkg.sv
source/smc_cfg_regs.sv
source/smc_strobe.sv
source/smc_wr_enable.sv
source/smc_data_path.sv
source/smc_lite.sv
tests/smc_sram_model.sv
tests/smc_lite_tb.sv

// File: Bender.yml
package:
  name: smc_lite

sources:
  - files:
      - source/smc_pkg.sv
      - source/smc_cfg_regs.sv
      - source/smc_strobe.sv
      - source/smc_wr_enable.sv
      - source/smc_data_path.sv
      - source/smc_lite.sv
  - target: test
    files:
      - tests/smc_sram_model.sv
      - tests/smc_lite_tb.sv

// File: tests/smc_lite_tb.sv
// testbench for the lite static memory controller
// drives host accesses and config writes against a shadow copy
// of the SRAM and checks latency, strobes, lanes and read data

module smc_lite_tb;

  import smc_pkg::*;

  localparam int          CLK_PERIOD = 20;
  localparam int          N_ACC      = 200;
  localparam int          ACC_CYC    = 50;
  localparam int          WATCHDOG   = N_ACC * ACC_CYC * CLK_PERIOD;
  localparam logic [31:0] SEED       = 32'h8157c6c6;

  logic              hclk;
  logic              rst_n;
  logic              req;
  smc_req_t          req_data;
  logic              cfg_wr;
  smc_cfg_t          cfg_wdata;
  logic              busy;
  logic              done;
  logic [DATA_W-1:0] rdata;
  smc_mem_t          mem;
  logic [DATA_W-1:0] mem_rdata;

  // ------------------------------
  // reference state
  // ------------------------------
  logic [DATA_W-1:0] shadow [256];
  smc_cfg_t          exp_cfg;
  // access currently driven by the host side
  smc_req_t          cur_req;
  logic [LANES-1:0]  exp_n_we;
  logic [ADDR_W-1:0] addr_q [$];

  smc_lite u_dut (
    .hclk      (hclk),
    .rst_n     (rst_n),
    .req       (req),
    .req_data  (req_data),
    .cfg_wr    (cfg_wr),
    .cfg_wdata (cfg_wdata),
    .busy      (busy),
    .done      (done),
    .rdata     (rdata),
    .mem       (mem),
    .mem_rdata (mem_rdata)
  );

  smc_sram_model u_mem (
    .hclk      (hclk),
    .mem       (mem),
    .mem_rdata (mem_rdata)
  );

  always #(CLK_PERIOD / 2) hclk = ~hclk;

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("mismatch %s: got %h expected %h", name, got, exp);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic abort_run(input string what);
    $display("error: %s", what);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // active-high lane select from size and low address bits
  function automatic logic [3:0] lane_sel(input smc_size_t size, input logic [1:0] a);
    logic [3:0] sel;
    case (size)
      SIZE_BYTE: sel = 4'b0001 << a;
      SIZE_HALF: sel = a[1] ? 4'b1100 : 4'b0011;
      default:   sel = 4'b1111;
    endcase
    return sel;
  endfunction

  // addressed byte or half moved down with zero upper bits
  function automatic logic [31:0] read_view(input logic [31:0] w, input smc_req_t r);
    logic [31:0] v;
    case (r.size)
      SIZE_BYTE: v = (w >> (8 * r.addr[1:0])) & 32'h0000_00ff;
      SIZE_HALF: v = (w >> (16 * r.addr[1])) & 32'h0000_ffff;
      default:   v = w;
    endcase
    return v;
  endfunction

  // narrow host data is copied from the low bits to every lane
  function automatic logic [31:0] merge_write(input logic [31:0] w, input smc_req_t r);
    logic [3:0]  sel;
    logic [31:0] src;
    logic [31:0] res;
    sel = lane_sel(r.size, r.addr[1:0]);
    case (r.size)
      SIZE_BYTE: src = {4{r.wdata[7:0]}};
      SIZE_HALF: src = {2{r.wdata[15:0]}};
      default:   src = r.wdata;
    endcase
    res = w;
    for (int i = 0; i < 4; i++)
    begin
      if (sel[i])
      begin
        res[8*i +: 8] = src[8*i +: 8];
      end
    end
    return res;
  endfunction

  function automatic smc_req_t make_req(input logic [ADDR_W-1:0] a,
                                        input logic [DATA_W-1:0] d,
                                        input smc_size_t s, input logic w);
    smc_req_t r;
    r.addr  = a;
    r.wdata = d;
    r.size  = s;
    r.write = w;
    return r;
  endfunction

  task automatic write_cfg(input logic [3:0] ts, input logic [3:0] tst, input logic [3:0] th);
    @(posedge hclk);
    cfg_wr    <= 1'b1;
    cfg_wdata <= '{t_setup: ts, t_strobe: tst, t_hold: th};
    @(posedge hclk);
    cfg_wr <= 1'b0;
    // zero fields behave as one
    exp_cfg.t_setup  = (ts == 0) ? 4'd1 : ts;
    exp_cfg.t_strobe = (tst == 0) ? 4'd1 : tst;
    exp_cfg.t_hold   = (th == 0) ? 4'd1 : th;
  endtask

  // ------------------------------
  // one access from req to done
  // ------------------------------
  // poke sends a cfg write and a second request mid access
  task automatic run_access(input smc_req_t r, input bit poke);
    int          sum;
    int          cycles;
    int          cs_low;
    int          wr_low;
    int          exp_wr;
    logic [31:0] exp_rd;
    smc_req_t    stray;
    sum    = int'(exp_cfg.t_setup) + int'(exp_cfg.t_strobe) + int'(exp_cfg.t_hold);
    exp_wr = r.write ? int'(exp_cfg.t_strobe) : 0;
    stray  = make_req(r.addr ^ 16'h0040, 32'hdead_beef, SIZE_WORD, 1'b1);
    cycles = 0;
    cs_low = 0;
    wr_low = 0;
    @(posedge hclk);
    req      <= 1'b1;
    req_data <= r;
    cur_req  <= r;
    // accept edge
    @(posedge hclk);
    req <= 1'b0;
    do
    begin
      @(posedge hclk);
      cycles++;
      cs_low += int'(!mem.n_cs);
      wr_low += int'(!mem.n_wr);
      // busy covers every cycle up to and including done
      assert (busy)
      else abort_run("busy dropped before the end of an access");
      if (poke && cycles == 2)
      begin
        cfg_wr    <= 1'b1;
        cfg_wdata <= '{t_setup: 4'd7, t_strobe: 4'd7, t_hold: 4'd7};
        req       <= 1'b1;
        req_data  <= stray;
      end
      else if (poke && cycles == 3)
      begin
        cfg_wr <= 1'b0;
        req    <= 1'b0;
      end
    end
    while (!done && cycles < ACC_CYC);
    assert (done)
    else abort_run($sformatf("no done pulse within %0d cycles of a request", ACC_CYC));
    assert (cycles == sum + 1)
    else report_mismatch("latency", cycles, sum + 1);
    assert (cs_low == sum)
    else report_mismatch("n_cs low cycles", cs_low, sum);
    assert (wr_low == exp_wr)
    else report_mismatch("n_wr low cycles", wr_low, exp_wr);
    if (r.write)
    begin
      shadow[r.addr[9:2]] = merge_write(shadow[r.addr[9:2]], r);
    end
    else
    begin
      exp_rd = read_view(shadow[r.addr[9:2]], r);
      assert (rdata == exp_rd)
      else report_mismatch("rdata", rdata, exp_rd);
    end
  endtask

  // ------------------------------
  // bus monitors
  // ------------------------------
  always @(posedge hclk)
  begin
    if (rst_n)
    begin
      // lanes follow the rule only inside the write strobe
      exp_n_we = mem.n_wr ? 4'hf : ~lane_sel(cur_req.size, cur_req.addr[1:0]);
      assert (mem.n_we == exp_n_we)
      else report_mismatch("n_we", 32'(mem.n_we), 32'(exp_n_we));
    end
  end

  done_pulse: assert property (@(posedge hclk) disable iff (!rst_n) done |=> !done)
    else abort_run("done stayed high for more than one cycle");
  done_busy: assert property (@(posedge hclk) disable iff (!rst_n) done |-> busy)
    else abort_run("done pulse while busy was low");
  wr_cs: assert property (@(posedge hclk) disable iff (!rst_n)
                          !mem.n_wr |-> (!mem.n_cs && mem.n_oe))
    else abort_run("write strobe without chip select or during output enable");

  // ------------------------------
  // stimulus
  // ------------------------------
  initial
  begin
    logic [ADDR_W-1:0] a;
    smc_size_t         sz;
    void'($urandom(SEED));
    hclk      = 1'b0;
    rst_n     = 1'b0;
    req       = 1'b0;
    req_data  = '0;
    cfg_wr    = 1'b0;
    cfg_wdata = '0;
    cur_req   = '0;
    // reset timing of setup, strobe and hold
    exp_cfg   = '{t_setup: 4'd1, t_strobe: 4'd2, t_hold: 4'd1};
    repeat (4) @(posedge hclk);
    rst_n <= 1'b1;
    @(posedge hclk);

    // reset state and one access at default timing
    assert ({mem.n_cs, mem.n_oe, mem.n_we, mem.n_wr} == 7'h7f)
    else report_mismatch("mem controls", {mem.n_cs, mem.n_oe, mem.n_we, mem.n_wr}, 32'h7f);
    assert (!busy && !done)
    else abort_run("busy or done set after reset");
    for (int i = 0; i < 256; i++)
    begin
      shadow[i] = u_mem.words[i];
    end
    run_access(make_req(16'h0010, 32'h0, SIZE_WORD, 1'b0), 1'b0);

    // word writes read back in order
    for (int n = 0; n < 20; n++)
    begin
      a = 16'($urandom);
      addr_q.push_back(a);
      run_access(make_req(a, $urandom, SIZE_WORD, 1'b1), 1'b0);
    end
    while (addr_q.size() > 0)
    begin
      a = addr_q.pop_front();
      run_access(make_req(a, 32'h0, SIZE_WORD, 1'b0), 1'b0);
    end

    // narrow writes packed into eight words
    for (int n = 0; n < 24; n++)
    begin
      a  = 16'h0100 + 16'($urandom_range(31));
      sz = ($urandom_range(1) == 0) ? SIZE_BYTE : SIZE_HALF;
      run_access(make_req(a, $urandom, sz, 1'b1), 1'b0);
    end
    for (int n = 0; n < 8; n++)
    begin
      run_access(make_req(16'h0100 + 16'(4 * n), 32'h0, SIZE_WORD, 1'b0), 1'b0);
    end

    // narrow reads anywhere
    for (int n = 0; n < 24; n++)
    begin
      a  = 16'($urandom);
      sz = ($urandom_range(1) == 0) ? SIZE_BYTE : SIZE_HALF;
      run_access(make_req(a, 32'h0, sz, 1'b0), 1'b0);
    end

    // all fields zero
    write_cfg(4'd0, 4'd0, 4'd0);
    a = 16'($urandom);
    run_access(make_req(a, $urandom, SIZE_WORD, 1'b1), 1'b0);
    run_access(make_req(a, 32'h0, SIZE_WORD, 1'b0), 1'b0);

    // programmable timing with zero fields
    for (int n = 0; n < 8; n++)
    begin
      write_cfg(4'($urandom_range(7)), 4'($urandom_range(7)), 4'($urandom_range(7)));
      a = 16'($urandom);
      run_access(make_req(a, $urandom, SIZE_WORD, 1'b1), 1'b0);
      run_access(make_req(a, 32'h0, SIZE_WORD, 1'b0), 1'b0);
    end

    // cfg write and request while busy are both dropped
    write_cfg(4'd2, 4'd3, 4'd1);
    a = 16'h0200;
    run_access(make_req(a, $urandom, SIZE_WORD, 1'b1), 1'b1);
    repeat (30)
    begin
      @(posedge hclk);
      assert (!done && !busy)
      else abort_run("a request issued while busy started another access");
    end
    run_access(make_req(a ^ 16'h0040, 32'h0, SIZE_WORD, 1'b0), 1'b0);

    $display("ALL CHECKS PASSED");
    $finish;
  end

  // watchdog
  initial
  begin
    #(WATCHDOG);
    $display("error: run timed out after %0d time units", WATCHDOG);
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: tests/smc_sram_model.sv
// behavioral asynchronous SRAM for the controller testbench
// 256 words of byte lanes, written on the clock edge while
// chip select and write strobe are low, read while n_oe is low

module smc_sram_model (
  input  logic                       hclk,
  input  smc_pkg::smc_mem_t          mem,
  output logic [smc_pkg::DATA_W-1:0] mem_rdata
);

  import smc_pkg::*;

  localparam int DEPTH = 256;

  logic [DATA_W-1:0] words [DEPTH];
  logic [7:0]        idx;

  // word index from the byte address
  assign idx = mem.addr[9:2];

  // power-up fill, every byte tied to the word index
  initial
  begin
    for (int i = 0; i < DEPTH; i++)
    begin
      words[i] <= {8'(i) ^ 8'h5a, 8'(i), ~8'(i), 8'(i) ^ 8'hc3};
    end
  end

  // lane writes on the clock edge
  always @(posedge hclk)
  begin
    if (!mem.n_cs && !mem.n_wr)
    begin
      for (int l = 0; l < LANES; l++)
      begin
        if (!mem.n_we[l])
        begin
          words[idx][8*l +: 8] <= mem.wdata[8*l +: 8];
        end
      end
    end
  end

  // bus floats to zero when not read
  assign mem_rdata = mem.n_oe ? '0 : words[idx];

endmodule

// File: source/smc_lite.sv
// static memory controller, lite top level
// single chip select SRAM-style controller: config registers,
// phase sequencer, write enable gating and data path,
// with the external pins packed into one bus struct

module smc_lite (
  input  logic                       hclk,
  input  logic                       rst_n,
  input  logic                       req,
  input  smc_pkg::smc_req_t          req_data,
  input  logic                       cfg_wr,
  input  smc_pkg::smc_cfg_t          cfg_wdata,
  output logic                       busy,
  output logic                       done,
  output logic [smc_pkg::DATA_W-1:0] rdata,
  output smc_pkg::smc_mem_t          mem,
  input  logic [smc_pkg::DATA_W-1:0] mem_rdata
);

  import smc_pkg::*;

  // ------------------------------
  // internal wires
  // ------------------------------
  smc_cfg_t          cfg;
  logic              latch;
  logic              capture;
  logic              r_full;
  logic              n_cs;
  logic              n_oe;
  logic              n_r_wr;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  smc_size_t         size;
  logic              write;
  logic [LANES-1:0]  n_we;
  logic              n_wr;

  smc_cfg_regs u_cfg_regs (
    .hclk      (hclk),
    .rst_n     (rst_n),
    .cfg_wr    (cfg_wr),
    .cfg_wdata (cfg_wdata),
    .busy      (busy),
    .cfg       (cfg)
  );

  smc_strobe u_strobe (
    .hclk    (hclk),
    .rst_n   (rst_n),
    .req     (req),
    .write   (write),
    .cfg     (cfg),
    .busy    (busy),
    .done    (done),
    .latch   (latch),
    .capture (capture),
    .r_full  (r_full),
    .n_cs    (n_cs),
    .n_oe    (n_oe),
    .n_r_wr  (n_r_wr)
  );

  smc_wr_enable u_wr_enable (
    .r_full  (r_full),
    .n_r_wr  (n_r_wr),
    .size    (size),
    .addr_lo (addr[1:0]),
    .n_we    (n_we),
    .n_wr    (n_wr)
  );

  smc_data_path u_data_path (
    .hclk      (hclk),
    .rst_n     (rst_n),
    .latch     (latch),
    .capture   (capture),
    .req_data  (req_data),
    .mem_rdata (mem_rdata),
    .addr      (addr),
    .wdata     (wdata),
    .size      (size),
    .write     (write),
    .rdata     (rdata)
  );

  // pin bundle toward the device
  assign mem = '{addr: addr, wdata: wdata, n_cs: n_cs, n_oe: n_oe, n_we: n_we, n_wr: n_wr};

endmodule

// File: source/smc_data_path.sv
// static memory controller, data path
// latches the accepted request, replicates narrow write data
// across the byte lanes, and captures read data aligned down
// to bit 0 with zero extension

module smc_data_path (
  input  logic                       hclk,
  input  logic                       rst_n,
  input  logic                       latch,
  input  logic                       capture,
  input  smc_pkg::smc_req_t          req_data,
  input  logic [smc_pkg::DATA_W-1:0] mem_rdata,
  output logic [smc_pkg::ADDR_W-1:0] addr,
  output logic [smc_pkg::DATA_W-1:0] wdata,
  output smc_pkg::smc_size_t         size,
  output logic                       write,
  output logic [smc_pkg::DATA_W-1:0] rdata
);

  import smc_pkg::*;

  smc_req_t          req_q;
  logic [DATA_W-1:0] rd_aligned;

  // ------------------------------
  // request latch
  // ------------------------------
  always_ff @(posedge hclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      req_q <= '0;
    end
    else if (latch)
    begin
      req_q <= req_data;
    end
  end

  assign addr = req_q.addr;
  assign size = req_q.size;
  // incoming op forwarded on the accept edge,
  // the sequencer sets n_oe from it in the same cycle
  assign write = latch ? req_data.write : req_q.write;

  // lane replication, host data is right aligned
  always_comb
  begin
    case (req_q.size)
      SIZE_BYTE: wdata = {LANES{req_q.wdata[7:0]}};
      SIZE_HALF: wdata = {2{req_q.wdata[15:0]}};
      default:   wdata = req_q.wdata;
    endcase
  end

  // ------------------------------
  // read alignment
  // ------------------------------
  always_comb
  begin
    case (req_q.size)
      SIZE_BYTE: rd_aligned = {24'd0, mem_rdata[8*req_q.addr[1:0] +: 8]};
      SIZE_HALF: rd_aligned = {16'd0, mem_rdata[16*req_q.addr[1] +: 16]};
      default:   rd_aligned = mem_rdata;
    endcase
  end

  // held until the next read capture
  always_ff @(posedge hclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rdata <= '0;
    end
    else if (capture)
    begin
      rdata <= rd_aligned;
    end
  end

endmodule

// File: source/smc_wr_enable.sv
// static memory controller, write enable gating
// decodes active byte lanes from size and low address bits,
// then gates lane enables and write strobe with r_full so they
// only assert inside the full-cycle strobe phase

module smc_wr_enable (
  input  logic               r_full,
  input  logic               n_r_wr,
  input  smc_pkg::smc_size_t size,
  input  logic [1:0]         addr_lo,
  output logic [3:0]         n_we,
  output logic               n_wr
);

  import smc_pkg::*;

  // raw active-low lane mask, held for the pending write
  logic [LANES-1:0] n_r_we;

  // ------------------------------
  // lane decode
  // ------------------------------
  always_comb
  begin
    case (size)
      SIZE_BYTE: n_r_we = ~(LANES'(1) << addr_lo);
      SIZE_HALF: n_r_we = addr_lo[1] ? 4'b0011 : 4'b1100;
      default:   n_r_we = 4'b0000;
    endcase
    // reads keep every lane off
    n_r_we = n_r_we | {LANES{n_r_wr}};
  end

  // ------------------------------
  // gate with full-cycle phase
  // ------------------------------
  assign n_we = {LANES{~r_full}} | n_r_we;
  assign n_wr = ~r_full | n_r_wr;

endmodule

// File: source/smc_strobe.sv
// static memory controller, access sequencer
// runs setup, strobe and hold phases for one access at a time,
// drives registered chip select, output enable and raw write
// strobe, the full-cycle phase level r_full, busy and done,
// plus the latch and capture pulses for the data path

module smc_strobe (
  input  logic              hclk,
  input  logic              rst_n,
  input  logic              req,
  input  logic              write,
  input  smc_pkg::smc_cfg_t cfg,
  output logic              busy,
  output logic              done,
  output logic              latch,
  output logic              capture,
  output logic              r_full,
  output logic              n_cs,
  output logic              n_oe,
  output logic              n_r_wr
);

  import smc_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_STROBE,
    ST_HOLD
  } state_t;

  state_t           state_q;
  // cycles left in the current phase
  logic [CNT_W-1:0] cnt_q;
  // per-access copy of the later phase lengths
  logic [CNT_W-1:0] t_strobe_q;
  logic [CNT_W-1:0] t_hold_q;
  logic             last;

  assign last = (cnt_q == CNT_W'(1));

  // request taken only when nothing is in flight
  assign latch = req & ~busy;

  // read data sampled at the end of the last strobe cycle
  assign capture = (state_q == ST_STROBE) & last & ~write;

  // timing snapshot, so a cfg write on the accept edge
  // does not split one access across two settings
  always_ff @(posedge hclk)
  begin
    if (latch)
    begin
      t_strobe_q <= cfg.t_strobe;
      t_hold_q   <= cfg.t_hold;
    end
  end

  // ------------------------------
  // phase FSM, registered strobes
  // ------------------------------
  always_ff @(posedge hclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
      busy    <= 1'b0;
      done    <= 1'b0;
      r_full  <= 1'b0;
      n_cs    <= 1'b1;
      n_oe    <= 1'b1;
      n_r_wr  <= 1'b1;
    end
    else
    begin
      // done is a single cycle pulse
      done <= 1'b0;
      case (state_q)
        ST_IDLE:
        begin
          if (latch)
          begin
            state_q <= ST_SETUP;
            cnt_q   <= cfg.t_setup;
            busy    <= 1'b1;
            n_cs    <= 1'b0;
            // output enable only for reads
            n_oe    <= write;
          end
          else
          begin
            // drops after the done cycle
            busy <= 1'b0;
          end
        end
        ST_SETUP:
        begin
          if (last)
          begin
            state_q <= ST_STROBE;
            cnt_q   <= t_strobe_q;
            r_full  <= 1'b1;
            n_r_wr  <= ~write;
          end
          else
          begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        ST_STROBE:
        begin
          if (last)
          begin
            state_q <= ST_HOLD;
            cnt_q   <= t_hold_q;
            r_full  <= 1'b0;
            n_r_wr  <= 1'b1;
            n_oe    <= 1'b1;
          end
          else
          begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        ST_HOLD:
        begin
          // chip select held through hold
          if (last)
          begin
            state_q <= ST_IDLE;
            n_cs    <= 1'b1;
            done    <= 1'b1;
          end
          else
          begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        default:
        begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

// File: source/smc_cfg_regs.sv
// static memory controller, timing configuration registers
// holds setup, strobe and hold lengths for the sequencer,
// loads defaults on reset and takes host writes only while idle
// so an access in flight keeps its timing

module smc_cfg_regs (
  input  logic              hclk,
  input  logic              rst_n,
  input  logic              cfg_wr,
  input  smc_pkg::smc_cfg_t cfg_wdata,
  input  logic              busy,
  output smc_pkg::smc_cfg_t cfg
);

  import smc_pkg::*;

  // a zero length phase is not allowed, store it as one
  function automatic logic [CNT_W-1:0] clamp_field(input logic [CNT_W-1:0] val);
    logic [CNT_W-1:0] res;
    res = val;
    if (val == '0)
    begin
      res = CNT_W'(1);
    end
    return res;
  endfunction

  // write is accepted only with the sequencer idle
  logic wr_ok;

  assign wr_ok = cfg_wr & ~busy;

  // ------------------------------
  // timing fields
  // ------------------------------
  always_ff @(posedge hclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cfg.t_setup  <= CFG_SETUP_RST;
      cfg.t_strobe <= CFG_STROBE_RST;
      cfg.t_hold   <= CFG_HOLD_RST;
    end
    else if (wr_ok)
    begin
      // all three fields move together
      cfg.t_setup  <= clamp_field(cfg_wdata.t_setup);
      cfg.t_strobe <= clamp_field(cfg_wdata.t_strobe);
      cfg.t_hold   <= clamp_field(cfg_wdata.t_hold);
    end
  end

endmodule

// File: source/smc_pkg.sv
// static memory controller, shared definitions
// bus widths, timing field width and reset defaults,
// access size encoding, host request, timing config
// and the external memory bus bundle

package smc_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;
  localparam int LANES  = 4;
  // each timing field counts 1..15 cycles
  localparam int CNT_W  = 4;

  // timing defaults after reset
  localparam logic [CNT_W-1:0] CFG_SETUP_RST  = 4'd1;
  localparam logic [CNT_W-1:0] CFG_STROBE_RST = 4'd2;
  localparam logic [CNT_W-1:0] CFG_HOLD_RST   = 4'd1;

  // ------------------------------
  // types
  // ------------------------------
  // access size
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } smc_size_t;

  // one host access, 51 bits
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    smc_size_t         size;
    logic              write;
  } smc_req_t;

  // phase lengths in hclk cycles, 12 bits
  typedef struct packed {
    logic [CNT_W-1:0] t_setup;
    logic [CNT_W-1:0] t_strobe;
    logic [CNT_W-1:0] t_hold;
  } smc_cfg_t;

  // pins toward the device, all strobes active low, 55 bits
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              n_cs;
    logic              n_oe;
    logic [LANES-1:0]  n_we;
    logic              n_wr;
  } smc_mem_t;

endpackage
